//--- include/pss_defs.svh
`ifndef PSS_DEFS_SVH
`define PSS_DEFS_SVH

// --------------------------------------------------
// sample format
// --------------------------------------------------

// one signed I or Q component
`define IQ_DW 12

// width of the running sample index
`define SAMPLE_ID_DW 32

// --------------------------------------------------
// correlation
// --------------------------------------------------

// window length, also taps per local sequence
`define PSS_LEN 16

// one local sequence per N_id_2
`define N_NID2 3

// 4 bits growth over 16 terms, 1 for the abs sum, 1 spare
`define METRIC_DW (`IQ_DW + 6)

// detections blocked for this many valid samples after a hit
`define PSS_HOLDOFF (`PSS_LEN - 1)

`endif

//--- hw/pss_pkg.sv
`include "pss_defs.svh"

package pss_pkg;

    // --------------------------------------------------
    // stream payloads
    // --------------------------------------------------

    // Q in the upper half, I in the lower half
    typedef struct packed {
        logic signed [`IQ_DW-1:0] q;
        logic signed [`IQ_DW-1:0] i;
    } sample_t;

    // unsigned |re| + |im| of one correlation
    typedef logic [`METRIC_DW-1:0] metric_t;

    typedef logic [1:0] nid2_t;

    typedef logic [`SAMPLE_ID_DW-1:0] sample_id_t;

    // --------------------------------------------------
    // local sequences
    // --------------------------------------------------

    // bit k is tap k, applied to window position k (oldest first)
    // 1 means +1, 0 means -1
    typedef logic [`PSS_LEN-1:0] tap_t;

    // fragments of three different m-sequences, none the
    // complement of another so the peaks stay unique
    localparam tap_t PSS_TAPS [`N_NID2] = '{
        16'h89AF,
        16'h7AC8,
        16'hE4B3
    };

endpackage

//--- hw/sample_window.sv
`timescale 1ns/10ps

`include "pss_defs.svh"

module sample_window (
    input  logic                 clk_i,
    input  logic                 reset_ni,

    input  logic                 in_valid_i,
    input  pss_pkg::sample_t     in_sample_i,

    output logic                 win_valid_o,
    output pss_pkg::sample_t     window_o [`PSS_LEN],
    output logic                 win_full_o,
    output pss_pkg::sample_id_t  win_id_o
);

    import pss_pkg::*;

    // index handed to the next accepted sample
    sample_id_t sample_cnt;

    // --------------------------------------------------
    // control
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            win_valid_o <= 1'b0;
            win_full_o  <= 1'b0;
            sample_cnt  <= '0;
        end else begin
            win_valid_o <= in_valid_i;
            if (in_valid_i) begin
                sample_cnt <= sample_cnt + 1'b1;
                // sticky once the first window is complete
                if (sample_cnt == sample_id_t'(`PSS_LEN - 1)) begin
                    win_full_o <= 1'b1;
                end
            end
        end
    end

    // --------------------------------------------------
    // shift register, oldest at index 0
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (in_valid_i) begin
            for (int k = 0; k < `PSS_LEN - 1; k++) begin
                window_o[k] <= window_o[k+1];
            end
            window_o[`PSS_LEN-1] <= in_sample_i;
            win_id_o             <= sample_cnt;
        end
    end

endmodule

//--- hw/pss_correlator.sv
`timescale 1ns/10ps

`include "pss_defs.svh"

module pss_correlator #(
    parameter int NID2 = 0
) (
    input  logic                 clk_i,
    input  logic                 reset_ni,

    input  logic                 win_valid_i,
    input  pss_pkg::sample_t     window_i [`PSS_LEN],
    input  logic                 win_full_i,
    input  pss_pkg::sample_id_t  win_id_i,

    output logic                 metric_valid_o,
    output pss_pkg::metric_t     metric_o,
    output logic                 metric_full_o,
    output pss_pkg::sample_id_t  metric_id_o
);

    import pss_pkg::*;

    // 16 terms of IQ_DW bits, signed
    localparam int   SUM_DW = `IQ_DW + 5;
    localparam tap_t TAPS   = PSS_TAPS[NID2];

    logic signed [SUM_DW-1:0] re_sum;
    logic signed [SUM_DW-1:0] im_sum;

    // stage one registers
    logic signed [SUM_DW-1:0] re_q;
    logic signed [SUM_DW-1:0] im_q;
    logic                     valid_q;
    logic                     full_q;
    sample_id_t               id_q;

    function automatic metric_t magnitude(input logic signed [SUM_DW-1:0] v);
        logic signed [`METRIC_DW-1:0] ext;
        ext = v;
        if (ext < 0) begin
            ext = -ext;
        end
        return metric_t'(ext);
    endfunction

    // --------------------------------------------------
    // sign-pattern correlation, adds and subtracts only
    // --------------------------------------------------
    always_comb begin
        re_sum = '0;
        im_sum = '0;
        for (int k = 0; k < `PSS_LEN; k++) begin
            if (TAPS[k]) begin
                re_sum = re_sum + window_i[k].i;
                im_sum = im_sum + window_i[k].q;
            end else begin
                re_sum = re_sum - window_i[k].i;
                im_sum = im_sum - window_i[k].q;
            end
        end
    end

    // stage one
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            valid_q <= 1'b0;
            full_q  <= 1'b0;
        end else begin
            valid_q <= win_valid_i;
            if (win_valid_i) begin
                full_q <= win_full_i;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (win_valid_i) begin
            re_q <= re_sum;
            im_q <= im_sum;
            id_q <= win_id_i;
        end
    end

    // --------------------------------------------------
    // stage two, |re| + |im|
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            metric_valid_o <= 1'b0;
            metric_full_o  <= 1'b0;
        end else begin
            metric_valid_o <= valid_q;
            if (valid_q) begin
                metric_full_o <= full_q;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_q) begin
            metric_o    <= magnitude(re_q) + magnitude(im_q);
            metric_id_o <= id_q;
        end
    end

endmodule

//--- hw/peak_detector.sv
`timescale 1ns/10ps

`include "pss_defs.svh"

module peak_detector (
    input  logic                 clk_i,
    input  logic                 reset_ni,

    input  logic                 metric_valid_i,
    input  pss_pkg::metric_t     metric_i [`N_NID2],
    input  logic                 metric_full_i,
    input  pss_pkg::sample_id_t  metric_id_i,
    input  pss_pkg::metric_t     threshold_i,

    output logic                 det_valid_o,
    output pss_pkg::nid2_t       det_nid2_o,
    output pss_pkg::sample_id_t  det_id_o
);

    import pss_pkg::*;

    localparam int HOLD_W = $clog2(`PSS_HOLDOFF + 1);

    metric_t           max_val;
    nid2_t             max_nid;
    logic [HOLD_W-1:0] holdoff_cnt;
    logic              fire;

    // --------------------------------------------------
    // arg max over the three sequences
    // --------------------------------------------------
    always_comb begin
        max_val = metric_i[0];
        max_nid = '0;
        // strict compare keeps the lowest N_id_2 on a tie
        for (int n = 1; n < `N_NID2; n++) begin
            if (metric_i[n] > max_val) begin
                max_val = metric_i[n];
                max_nid = nid2_t'(n);
            end
        end
    end

    assign fire = metric_valid_i && metric_full_i &&
                  (max_val >= threshold_i) && (holdoff_cnt == '0);

    // --------------------------------------------------
    // holdoff counts valid samples, not clock cycles
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            det_valid_o <= 1'b0;
            holdoff_cnt <= '0;
        end else begin
            det_valid_o <= fire;
            if (fire) begin
                holdoff_cnt <= HOLD_W'(`PSS_HOLDOFF);
            end else if (metric_valid_i && holdoff_cnt != '0) begin
                holdoff_cnt <= holdoff_cnt - 1'b1;
            end
        end
    end

    // detection payload, held until the next hit
    always_ff @(posedge clk_i) begin
        if (fire) begin
            det_nid2_o <= max_nid;
            det_id_o   <= metric_id_i;
        end
    end

endmodule

//--- hw/pss_search.sv
`timescale 1ns/10ps

`include "pss_defs.svh"

module pss_search (
    input  logic                 clk_i,
    input  logic                 reset_ni,

    input  logic                 in_valid_i,
    input  pss_pkg::sample_t     in_sample_i,
    input  pss_pkg::metric_t     threshold_i,

    output logic                 det_valid_o,
    output pss_pkg::nid2_t       det_nid2_o,
    output pss_pkg::sample_id_t  det_id_o
);

    import pss_pkg::*;

    // window to correlators
    logic       win_valid;
    sample_t    window [`PSS_LEN];
    logic       win_full;
    sample_id_t win_id;

    // correlators to peak detector
    logic       metric_valid [`N_NID2];
    metric_t    metric       [`N_NID2];
    logic       metric_full  [`N_NID2];
    sample_id_t metric_id    [`N_NID2];

    sample_window u_window (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .in_valid_i  (in_valid_i),
        .in_sample_i (in_sample_i),
        .win_valid_o (win_valid),
        .window_o    (window),
        .win_full_o  (win_full),
        .win_id_o    (win_id)
    );

    // --------------------------------------------------
    // one correlator per N_id_2
    // --------------------------------------------------
    for (genvar n = 0; n < `N_NID2; n++) begin : g_corr
        pss_correlator #(
            .NID2 (n)
        ) u_corr (
            .clk_i          (clk_i),
            .reset_ni       (reset_ni),
            .win_valid_i    (win_valid),
            .window_i       (window),
            .win_full_i     (win_full),
            .win_id_i       (win_id),
            .metric_valid_o (metric_valid[n]),
            .metric_o       (metric[n]),
            .metric_full_o  (metric_full[n]),
            .metric_id_o    (metric_id[n])
        );
    end

    // lanes run in lockstep, lane 0 carries the shared sideband
    peak_detector u_peak (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .metric_valid_i (metric_valid[0]),
        .metric_i       (metric),
        .metric_full_i  (metric_full[0]),
        .metric_id_i    (metric_id[0]),
        .threshold_i    (threshold_i),
        .det_valid_o    (det_valid_o),
        .det_nid2_o     (det_nid2_o),
        .det_id_o       (det_id_o)
    );

endmodule

//--- sim/pss_search_tb.sv
`timescale 1ns/10ps

`include "pss_defs.svh"

module pss_search_tb #(
    parameter int SEED = 39
);

    import pss_pkg::*;

    // --------------------------------------------------
    // test constants
    // --------------------------------------------------
    localparam int AMP           = 1000;
    localparam int CLEAN_PEAK    = `PSS_LEN * AMP;
    // high enough that no partial overlap or cross term reaches it
    localparam int CLEAN_THR     = CLEAN_PEAK * 7 / 8;
    localparam int NOISE_THR     = 9000;
    localparam int LEAD_ZEROS    = 20;
    localparam int REPEATS       = 3;
    localparam int MAX_GAP       = 3;
    localparam int NOISE_SAMPLES = 200;
    localparam int RESET_CYCLES  = 5;
    localparam int PIPE_LAT      = 4;

    // cycles per run, used for the timeout
    localparam int SETUP_CYC   = RESET_CYCLES + 1 + PIPE_LAT + 2;
    localparam int SEQ_CYC     = SETUP_CYC + LEAD_ZEROS + `PSS_LEN;
    localparam int GAP_CYC     = SETUP_CYC + (LEAD_ZEROS + `PSS_LEN) * (MAX_GAP + 1);
    localparam int CYCLE_LIMIT = SETUP_CYC + `PSS_LEN
                               + 5 * SEQ_CYC
                               + SETUP_CYC + LEAD_ZEROS + REPEATS * `PSS_LEN
                               + 3 * GAP_CYC
                               + SETUP_CYC + NOISE_SAMPLES * (MAX_GAP + 1)
                               + 50;

    logic       clk_i;
    logic       reset_ni;
    logic       in_valid_i;
    sample_t    in_sample_i;
    metric_t    threshold_i;
    logic       det_valid_o;
    nid2_t      det_nid2_o;
    sample_id_t det_id_o;

    int     cycle = 0;
    integer seed;
    int     error_count = 0;
    int     check_count = 0;
    int     test_count  = 0;

    // reference model state
    int     win_i [`PSS_LEN];
    int     win_q [`PSS_LEN];
    int     model_count;
    int     model_hold;
    int     model_thr;
    int     model_dets;
    int     exp_nid   [$];
    longint exp_id    [$];
    int     exp_cycle [$];

    // detections seen from the DUT in the current test
    int     seen_nid [$];
    longint seen_id  [$];

    pss_search uut (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .in_valid_i  (in_valid_i),
        .in_sample_i (in_sample_i),
        .threshold_i (threshold_i),
        .det_valid_o (det_valid_o),
        .det_nid2_o  (det_nid2_o),
        .det_id_o    (det_id_o)
    );

    // --------------------------------------------------
    // clock, cycle count and timeout
    // --------------------------------------------------
    always #10 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle <= cycle + 1;
        if (cycle >= CYCLE_LIMIT) begin
            $display("run stopped at cycle %0d before the tests completed", cycle);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    task automatic check_value(input string name, input longint expected,
                               input longint actual);
        check_count++;
        if (expected != actual) begin
            $display("Error: time %0t, %s expected %0d, got %0d",
                     $time, name, expected, actual);
            error_count++;
        end
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk_i) begin
        if (reset_ni === 1'b1 && det_valid_o === 1'b1) begin
            seen_nid.push_back(int'(det_nid2_o));
            seen_id.push_back(longint'(det_id_o));
            if (exp_id.size() == 0) begin
                $display("unexpected detection at time %0t, N_id_2 %0d, sample %0d",
                         $time, det_nid2_o, det_id_o);
                error_count++;
            end else begin
                check_value("det_nid2_o", exp_nid.pop_front(), det_nid2_o);
                check_value("det_id_o", exp_id.pop_front(), det_id_o);
                check_value("det_valid_o cycle", exp_cycle.pop_front(), cycle);
            end
        end
    end

    // --------------------------------------------------
    // reference model
    // --------------------------------------------------
    function automatic int abs_int(input int v);
        return (v < 0) ? -v : v;
    endfunction

    task automatic clear_model();
        for (int k = 0; k < `PSS_LEN; k++) begin
            win_i[k] = 0;
            win_q[k] = 0;
        end
        model_count = 0;
        model_hold  = 0;
        model_dets  = 0;
        exp_nid.delete();
        exp_id.delete();
        exp_cycle.delete();
    endtask

    task automatic predict_sample(input int i_val, input int q_val, input int valid_cycle);
        int metric [`N_NID2];
        int re;
        int im;
        int best;
        int best_nid;
        for (int k = 0; k < `PSS_LEN - 1; k++) begin
            win_i[k] = win_i[k+1];
            win_q[k] = win_q[k+1];
        end
        win_i[`PSS_LEN-1] = i_val;
        win_q[`PSS_LEN-1] = q_val;
        for (int n = 0; n < `N_NID2; n++) begin
            re = 0;
            im = 0;
            for (int k = 0; k < `PSS_LEN; k++) begin
                re = PSS_TAPS[n][k] ? re + win_i[k] : re - win_i[k];
                im = PSS_TAPS[n][k] ? im + win_q[k] : im - win_q[k];
            end
            metric[n] = abs_int(re) + abs_int(im);
        end
        best     = metric[0];
        best_nid = 0;
        for (int n = 1; n < `N_NID2; n++) begin
            if (metric[n] > best) begin
                best     = metric[n];
                best_nid = n;
            end
        end
        // full once PSS_LEN samples are in, holdoff counts valid samples
        if (model_count >= `PSS_LEN - 1 && best >= model_thr && model_hold == 0) begin
            exp_nid.push_back(best_nid);
            exp_id.push_back(model_count);
            exp_cycle.push_back(valid_cycle + PIPE_LAT);
            model_hold = `PSS_LEN - 1;
            model_dets++;
        end else if (model_hold != 0) begin
            model_hold--;
        end
        model_count++;
    endtask

    // --------------------------------------------------
    // stimulus
    // --------------------------------------------------
    task automatic apply_reset();
        @(posedge clk_i);
        reset_ni   <= 1'b0;
        in_valid_i <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        reset_ni <= 1'b1;
        clear_model();
        seen_nid.delete();
        seen_id.delete();
    endtask

    task automatic set_threshold(input int value);
        threshold_i <= metric_t'(value);
        model_thr = value;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk_i);
            in_valid_i <= 1'b0;
        end
    endtask

    task automatic send_sample(input int i_val, input int q_val, input int gap_max);
        sample_t smp;
        int      gap;
        if (gap_max > 0) begin
            gap = $unsigned($random(seed)) % (gap_max + 1);
            idle_cycles(gap);
        end
        smp.i = i_val[`IQ_DW-1:0];
        smp.q = q_val[`IQ_DW-1:0];
        @(posedge clk_i);
        in_valid_i  <= 1'b1;
        in_sample_i <= smp;
        // counter still holds the previous cycle here
        predict_sample(int'(smp.i), int'(smp.q), cycle + 1);
    endtask

    task automatic send_zeros(input int n, input int gap_max);
        for (int k = 0; k < n; k++) begin
            send_sample(0, 0, gap_max);
        end
    endtask

    // I is +-AMP by tap sign, Q stays zero
    task automatic send_sequence(input int nid, input int gap_max);
        for (int k = 0; k < `PSS_LEN; k++) begin
            send_sample(PSS_TAPS[nid][k] ? AMP : -AMP, 0, gap_max);
        end
    endtask

    // let the four-stage pipeline drain
    task automatic settle_pipeline();
        idle_cycles(PIPE_LAT + 2);
        if (exp_id.size() != 0) begin
            $display("%0d expected detection(s) missing, first at sample %0d",
                     exp_id.size(), exp_id[0]);
            error_count++;
            exp_nid.delete();
            exp_id.delete();
            exp_cycle.delete();
        end
    endtask

    task automatic expect_one_detection(input int nid, input longint id);
        check_value("detection count", 1, seen_id.size());
        if (seen_id.size() > 0) begin
            check_value("det_nid2_o", nid, seen_nid[0]);
            check_value("det_id_o", id, seen_id[0]);
        end
    endtask

    task automatic report_test(input string name, input int err_start);
        test_count++;
        $display("%-22s done, %0d errors", name, error_count - err_start);
    endtask

    // --------------------------------------------------
    // directed tests
    // --------------------------------------------------
    task automatic reset_quiet();
        int err_start;
        err_start = error_count;
        apply_reset();
        set_threshold(0);
        for (int k = 0; k < `PSS_LEN - 1; k++) begin
            send_sample(PSS_TAPS[0][k] ? 2047 : -2047, 2047, 0);
        end
        settle_pipeline();
        check_value("detection count", 0, seen_id.size());
        report_test("reset quiet", err_start);
    endtask

    task automatic clean_detection(input int nid);
        int err_start;
        err_start = error_count;
        apply_reset();
        set_threshold(CLEAN_THR);
        send_zeros(LEAD_ZEROS, 0);
        send_sequence(nid, 0);
        settle_pipeline();
        expect_one_detection(nid, LEAD_ZEROS + `PSS_LEN - 1);
        report_test($sformatf("clean nid2 %0d", nid), err_start);
    endtask

    task automatic threshold_edge();
        int err_start;
        err_start = error_count;
        // one above the clean peak
        apply_reset();
        set_threshold(CLEAN_PEAK + 1);
        send_zeros(LEAD_ZEROS, 0);
        send_sequence(1, 0);
        settle_pipeline();
        check_value("detection count", 0, seen_id.size());
        // exactly at the clean peak
        apply_reset();
        set_threshold(CLEAN_PEAK);
        send_zeros(LEAD_ZEROS, 0);
        send_sequence(1, 0);
        settle_pipeline();
        expect_one_detection(1, LEAD_ZEROS + `PSS_LEN - 1);
        report_test("threshold", err_start);
    endtask

    task automatic holdoff_spacing();
        int err_start;
        err_start = error_count;
        apply_reset();
        set_threshold(CLEAN_THR);
        send_zeros(LEAD_ZEROS, 0);
        for (int r = 0; r < REPEATS; r++) begin
            send_sequence(2, 0);
        end
        settle_pipeline();
        check_value("detection count", REPEATS, seen_id.size());
        if (seen_id.size() > 0) begin
            check_value("det_id_o", LEAD_ZEROS + `PSS_LEN - 1, seen_id[0]);
        end
        for (int j = 1; j < seen_id.size(); j++) begin
            check_value("det_id_o spacing", `PSS_LEN, seen_id[j] - seen_id[j-1]);
            check_value("det_nid2_o", 2, seen_nid[j]);
        end
        report_test("holdoff", err_start);
    endtask

    task automatic valid_gaps(input int nid);
        int err_start;
        err_start = error_count;
        apply_reset();
        set_threshold(CLEAN_THR);
        send_zeros(LEAD_ZEROS, MAX_GAP);
        send_sequence(nid, MAX_GAP);
        settle_pipeline();
        // same result as the gap-free run
        expect_one_detection(nid, LEAD_ZEROS + `PSS_LEN - 1);
        report_test($sformatf("gaps nid2 %0d", nid), err_start);
    endtask

    // idle gaps make the holdoff span clock cycles without samples
    task automatic noise_stream();
        int err_start;
        err_start = error_count;
        apply_reset();
        set_threshold(NOISE_THR);
        for (int k = 0; k < NOISE_SAMPLES; k++) begin
            send_sample($random(seed), $random(seed), MAX_GAP);
        end
        settle_pipeline();
        check_value("detection count", model_dets, seen_id.size());
        report_test($sformatf("noise, %0d hits", model_dets), err_start);
    endtask

    // --------------------------------------------------
    // main sequence
    // --------------------------------------------------
    initial begin
        clk_i       = 1'b0;
        reset_ni    = 1'b0;
        in_valid_i  = 1'b0;
        in_sample_i = '0;
        threshold_i = '0;
        seed        = SEED;
        model_thr   = 0;
        clear_model();

        reset_quiet();
        for (int n = 0; n < `N_NID2; n++) begin
            clean_detection(n);
        end
        threshold_edge();
        holdoff_spacing();
        for (int n = 0; n < `N_NID2; n++) begin
            valid_gaps(n);
        end
        noise_stream();

        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- src.f
+incdir+include
hw/pss_pkg.sv
hw/sample_window.sv
hw/pss_correlator.sv
hw/peak_detector.sv
hw/pss_search.sv
sim/pss_search_tb.sv

//--- Makefile
# Verilator build and run of the PSS search testbench

SIM      ?= verilator
TOP      ?= pss_search_tb
LOG      ?= sim.log
SEED     ?= 39
BUILD    ?= obj_dir
FILELIST ?= src.f
VFLAGS   ?= --binary --timing -Wno-fatal -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build $(TOP) with $(SIM), run it into $(LOG), check for the pass line"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "variables: SIM TOP LOG SEED BUILD FILELIST VFLAGS"

test:
	$(SIM) $(VFLAGS) --top-module $(TOP) -GSEED=$(SEED) -f $(FILELIST) \
		--Mdir $(BUILD) -o V$(TOP)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
